//--- filelist.f
+incdir+verilog
verilog/vdec_pkg.sv
verilog/vctrl_decode.sv
verilog/velem_counter.sv
verilog/voffset_gen.sv
verilog/vde_register.sv
verilog/vdecode_stage.sv
verif/vdec_clkgen.sv
verif/vdec_chk.sv
verif/vdec_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the vector decode stage testbench with Verilator.
# Exits non-zero when the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module vdec_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vvdec_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
echo "pass message not found"
exit 1

//--- verif/vdec_chk.sv
// concurrent checks on the decode/execute output of the vector decode stage
// bound into every vdecode_stage instance, failures are counted in fail_count
`timescale 1ns/1ns

module vdec_chk (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 stall,
  input logic                 flush,
  input vdec_pkg::de_bundle_t de_out
);
  int fail_count = 0;

  // output register stays quiet while reset is held
  reset_quiet: assert property (@(posedge CLK) !nRST |-> (!de_out.valid && de_out.wen == '0))
    else begin
      $error("valid or wen high while reset is asserted");
      fail_count++;
    end

  stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable(de_out))
    else begin
      $error("de_out changed during a stall");
      fail_count++;
    end

  flush_clear: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !de_out.valid)
    else begin
      $error("valid still high one cycle after a flush");
      fail_count++;
    end

endmodule

bind vdecode_stage vdec_chk chk0 (
  .CLK    (CLK),
  .nRST   (nRST),
  .stall  (stall),
  .flush  (flush),
  .de_out (de_out)
);

//--- verif/vdec_clkgen.sv
// free-running clock for the vector decode testbench
// period is twice HALF_NS, 4 ns by default
`timescale 1ns/1ns

module vdec_clkgen #(
  parameter int HALF_NS = 2
) (
  output logic CLK
);
  initial begin
    CLK = 1'b0;
    forever #HALF_NS CLK = ~CLK;
  end

endmodule

//--- verif/vdec_tb.sv
// random instruction test of the vector decode stage
// register file model answers from a hash of register number and element offset
// a new instruction starts only after v_busy has fallen
`timescale 1ns/1ns
`include "vdec_defines.svh"

module vdec_tb;
  import vdec_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int NUM_INSTR    = 300;
  localparam int TIMEOUT      = NUM_INSTR * 40 + RESET_CYCLES;

  typedef enum int {K_VV, K_VX, K_VI, K_UP, K_DOWN, K_GATHER, K_LOAD, K_STORE} kind_t;

  logic        CLK;
  logic        nRST;
  logic        v_start;
  logic [31:0] instr;
  vcfg_t       cfg;
  logic [31:0] xs1;
  logic [31:0] xs2;
  logic        stall;
  logic        flush;
  rf_rsp_t     rf_rsp;
  rf_req_t     rf_req;
  de_bundle_t  de_out;
  logic        v_busy;

  integer seed;
  int     err_count;
  int     check_count;
  int     cycles = 0;
  bit     checking;

  // instruction in flight as seen by the model
  kind_t       m_kind;
  string       m_name;
  logic [4:0]  m_vs1;
  logic [4:0]  m_vs2;
  logic [4:0]  m_vd;
  logic        m_vm;
  logic [31:0] m_xs1;
  sew_t        m_eew;
  logic [31:0] m_evl;
  int          bundles;
  bit          started;
  bit          flushed;
  bit          prev_stall;
  bit          prev_flush;
  bit          busy_end;
  de_bundle_t  held;

  vdec_clkgen clkgen0 (.CLK(CLK));

  vdecode_stage dut0 (
    .CLK     (CLK),
    .nRST    (nRST),
    .v_start (v_start),
    .instr   (instr),
    .cfg     (cfg),
    .xs1     (xs1),
    .xs2     (xs2),
    .stall   (stall),
    .flush   (flush),
    .rf_rsp  (rf_rsp),
    .rf_req  (rf_req),
    .de_out  (de_out),
    .v_busy  (v_busy)
  );

  function automatic logic [31:0] rf_word(input logic [4:0] r, input logic [31:0] e);
    return (e * 32'h9e3779b1) ^ {r, 27'h0} ^ {27'h0, r} ^ 32'h5a5a0000;
  endfunction

  function automatic logic mask_bit(input logic [31:0] e);
    logic [31:0] h;
    h = e * 32'h2545f491 + 32'h01234567;
    return h[13];
  endfunction

  // register file, answers in the same cycle
  function automatic rf_rsp_t answer(input rf_req_t q);
    rf_rsp_t a;
    for (int i = 0; i < `VDEC_LANES; i++) begin
      a.vs1_data[i] = rf_word(q.vs1, q.vs1_off[i]);
      a.vs2_data[i] = rf_word(q.vs2, q.vs2_off[i]);
      a.vs3_data[i] = rf_word(q.vs3, q.vs3_off[i]);
      a.mask[i]     = mask_bit(q.vs1_off[i]);
    end
    return a;
  endfunction

  assign rf_rsp = answer(rf_req);

  // expected bundle for the pair starting at element off
  function automatic de_bundle_t expect_pair(input logic [31:0] off);
    de_bundle_t  b;
    logic [31:0] e;
    logic [31:0] v2off;
    b             = '0;
    b.valid       = 1'b1;
    b.vd          = m_vd;
    b.sew         = m_eew;
    b.elem_vl     = m_evl;
    b.decode_done = (off + 32'd2 >= m_evl);
    case (m_kind)
      K_UP:     b.op = VOP_SLIDE1UP;
      K_DOWN:   b.op = VOP_SLIDE1DOWN;
      K_GATHER: b.op = VOP_RGATHER;
      K_LOAD:   b.op = VOP_LOAD;
      K_STORE:  b.op = VOP_STORE;
      default:  b.op = VOP_ADD;
    endcase
    for (int i = 0; i < `VDEC_LANES; i++) begin
      e                = off + 32'(i);
      b.woffset[i]     = e;
      b.store_data[i]  = rf_word(m_vd, e);
      case (m_kind)
        K_VX, K_UP, K_DOWN: b.opnd[i] = m_xs1;
        K_VI:               b.opnd[i] = {{27{m_vs1[4]}}, m_vs1};
        default:            b.opnd[i] = rf_word(m_vs1, e);
      endcase
      case (m_kind)
        K_UP:     v2off = e - 32'd1;
        K_DOWN:   v2off = e + 32'd1;
        K_GATHER: v2off = rf_word(m_vs1, e);
        default:  v2off = e;
      endcase
      // scalar fills the vacated element of a slide
      if ((m_kind == K_UP && v2off == 32'hffffffff) || (m_kind == K_DOWN && v2off == m_evl)) begin
        b.vs2[i] = m_xs1;
      end else begin
        b.vs2[i] = rf_word(m_vs2, v2off);
      end
      if (m_kind == K_STORE || e >= m_evl) begin
        b.wen[i] = 1'b0;
      end else if (!m_vm) begin
        b.wen[i] = mask_bit(e);
      end else begin
        b.wen[i] = 1'b1;
      end
    end
    return b;
  endfunction

  task automatic check(input string name, input logic [319:0] exp, input logic [319:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // random instruction and configuration, model state follows
  task automatic new_instr(output logic [31:0] word, output vcfg_t c);
    logic [31:0] r;
    logic [31:0] r2;
    logic [2:0]  w;
    int          sb;
    int          eb;
    r      = $random(seed);
    r2     = $random(seed);
    m_vs1  = r[4:0];
    m_vs2  = r[9:5];
    m_vd   = r[14:10];
    m_vm   = r[15];
    m_kind = kind_t'(r[18:16]);
    m_xs1  = $random(seed);
    sb     = int'(r2[7:0] % 8'd3);
    eb     = int'(r2[23:16] % 8'd3);
    c.sew  = sew_t'(sb[1:0]);
    c.vl   = 32'(r2[15:8] % 8'd17);
    c.lmul = r2[26:24];
    w      = (eb == 0) ? 3'b000 : (eb == 1) ? 3'b101 : 3'b110;
    m_eew  = c.sew;
    m_evl  = c.vl;
    case (m_kind)
      K_VV:     word = {6'b000000, m_vm, m_vs2, m_vs1, 3'b000, m_vd, 7'b1010111};
      K_VX:     word = {6'b000000, m_vm, m_vs2, m_vs1, 3'b100, m_vd, 7'b1010111};
      K_VI:     word = {6'b000000, m_vm, m_vs2, m_vs1, 3'b011, m_vd, 7'b1010111};
      K_UP:     word = {6'b001110, m_vm, m_vs2, m_vs1, 3'b110, m_vd, 7'b1010111};
      K_DOWN:   word = {6'b001111, m_vm, m_vs2, m_vs1, 3'b110, m_vd, 7'b1010111};
      K_GATHER: word = {6'b001100, m_vm, m_vs2, m_vs1, 3'b000, m_vd, 7'b1010111};
      default: begin
        // unit stride, nf and lumop zero
        m_vs2 = 5'd0;
        word  = {6'b000000, m_vm, 5'b00000, m_vs1, w, m_vd,
                 (m_kind == K_LOAD) ? 7'b0000111 : 7'b0100111};
        m_eew = sew_t'(eb[1:0]);
        if (eb < sb) begin
          m_evl = c.vl >> (sb - eb);
        end
      end
    endcase
    case (m_kind)
      K_VV:     m_name = "vadd.vv";
      K_VX:     m_name = "vadd.vx";
      K_VI:     m_name = "vadd.vi";
      K_UP:     m_name = "vslide1up";
      K_DOWN:   m_name = "vslide1down";
      K_GATHER: m_name = "vrgather.vv";
      K_LOAD:   m_name = "vle";
      default:  m_name = "vse";
    endcase
  endtask

  task automatic count_check();
    int n;
    if (started && !flushed) begin
      n = (m_evl == 0) ? 1 : int'((m_evl + 32'd1) / 32'd2);
      check($sformatf("%s bundle count", m_name), n, bundles);
    end
  endtask

  // output monitor, sampled away from the driving edge
  always @(negedge CLK) begin
    de_bundle_t exp_b;
    if (checking) begin
      // busy drops in the cycle after the last bundle is seen
      if (busy_end) begin
        check($sformatf("%s v_busy after last bundle", m_name), 0, v_busy);
        busy_end = 1'b0;
      end
      if (prev_flush) begin
        check($sformatf("%s valid after flush", m_name), 0, de_out.valid);
        check($sformatf("%s wen after flush", m_name), 0, de_out.wen);
      end else if (prev_stall) begin
        check($sformatf("%s bundle held in stall", m_name), held, de_out);
      end else if (de_out.valid) begin
        if (flushed) begin
          check($sformatf("%s valid bundle after flush", m_name), 0, 1);
        end else begin
          exp_b = expect_pair(32'(bundles * 2));
          check($sformatf("%s opnd", m_name), exp_b.opnd, de_out.opnd);
          check($sformatf("%s vs2", m_name), exp_b.vs2, de_out.vs2);
          check($sformatf("%s store_data", m_name), exp_b.store_data, de_out.store_data);
          check($sformatf("%s woffset", m_name), exp_b.woffset, de_out.woffset);
          check($sformatf("%s wen", m_name), exp_b.wen, de_out.wen);
          check($sformatf("%s op/vd/sew/elem_vl/done", m_name),
                {exp_b.op, exp_b.vd, exp_b.sew, exp_b.elem_vl, exp_b.decode_done},
                {de_out.op, de_out.vd, de_out.sew, de_out.elem_vl, de_out.decode_done});
          if (exp_b.decode_done) begin
            check($sformatf("%s v_busy with last bundle", m_name), 1, v_busy);
            busy_end = 1'b1;
          end
          bundles++;
        end
      end
      // gather reads vs2 at the vs1 data words
      if (m_kind == K_GATHER && started) begin
        for (int i = 0; i < `VDEC_LANES; i++) begin
          check($sformatf("%s vs2 read offset", m_name),
                rf_word(m_vs1, rf_req.vs1_off[i]), rf_req.vs2_off[i]);
        end
      end
      if (started) begin
        check($sformatf("%s rf_req registers and sew", m_name),
              {m_vs1, m_vs2, m_vd, m_eew},
              {rf_req.vs1, rf_req.vs2, rf_req.vs3, rf_req.sew});
      end
      if (flush) begin
        flushed = 1'b1;
      end
      prev_flush = flush;
      prev_stall = stall;
      held       = de_out;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    logic [31:0] word;
    vcfg_t       c;
    logic [31:0] r;
    seed        = 32'h27f1e602;
    err_count   = 0;
    check_count = 0;
    checking    = 1'b0;
    started     = 1'b0;
    flushed     = 1'b0;
    prev_stall  = 1'b0;
    prev_flush  = 1'b0;
    busy_end    = 1'b0;
    bundles     = 0;
    m_kind      = K_VV;
    nRST        = 1'b0;
    v_start     = 1'b0;
    instr       = '0;
    cfg         = '0;
    xs1         = '0;
    xs2         = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check("reset v_busy", 0, v_busy);
    check("reset valid", 0, de_out.valid);
    check("reset wen", 0, de_out.wen);
    check("reset decode_done", 0, de_out.decode_done);
    checking = 1'b1;

    for (int n = 0; n < NUM_INSTR; n++) begin
      @(posedge CLK);
      count_check();
      new_instr(word, c);
      started = 1'b1;
      flushed = 1'b0;
      bundles = 0;
      r       = $random(seed);
      instr   <= word;
      cfg     <= c;
      xs1     <= m_xs1;
      xs2     <= $random(seed);
      v_start <= 1'b1;
      stall   <= (r[2:0] == 3'd0);
      flush   <= 1'b0;
      @(negedge CLK);
      check($sformatf("%s v_busy on start", m_name), 1, v_busy);
      while (v_busy) begin
        @(posedge CLK);
        r       = $random(seed);
        v_start <= 1'b0;
        stall   <= (r[2:0] == 3'd0);
        flush   <= (r[9:5] == 5'd0);
        @(negedge CLK);
      end
    end

    @(posedge CLK);
    count_check();
    stall <= 1'b0;
    flush <= 1'b0;
    repeat (4) @(posedge CLK);
    $display("errors: %0d of %0d checks failed, %0d assertion failures",
             err_count, check_count, dut0.chk0.fail_count);
    if (err_count == 0 && dut0.chk0.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/vctrl_decode.sv
// combinational decode of one vector instruction
// instr and cfg must stay stable while the instruction is walked
// only unit-stride loads/stores with nf = 0 are legal
// an illegal instruction gets an element count of zero
`timescale 1ns/1ns
`include "vdec_defines.svh"

module vctrl_decode (
  input  logic [31:0]     instr,
  input  vdec_pkg::vcfg_t cfg,
  output vdec_pkg::vctrl_t ctrl
);
  import vdec_pkg::*;

  // major opcodes
  localparam logic [6:0] OPC_OPV   = 7'b1010111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000111;
  localparam logic [6:0] OPC_STORE = 7'b0100111;

  // OP-V funct3 categories
  localparam logic [2:0] F3_IVV = 3'b000;
  localparam logic [2:0] F3_IVI = 3'b011;
  localparam logic [2:0] F3_IVX = 3'b100;
  localparam logic [2:0] F3_MVX = 3'b110;

  localparam logic [5:0] F6_VADD       = 6'b000000;
  localparam logic [5:0] F6_VRGATHER   = 6'b001100;
  localparam logic [5:0] F6_VSLIDE1UP  = 6'b001110;
  localparam logic [5:0] F6_VSLIDE1DN  = 6'b001111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic [1:0] mop;
  logic [2:0] nf;
  width_t     ls_width;
  logic       ls_legal;
  logic [1:0] ls_shift;
  sew_t       ls_eew;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct6   = instr[31:26];
  assign mop      = instr[27:26];
  assign nf       = instr[31:29];
  assign ls_width = width_t'(instr[14:12]);

  // element width and vl scaling of a unit-stride access
  always_comb begin
    ls_legal = 1'b1;
    ls_eew   = SEW32;
    case (ls_width)
      WIDTH8:  ls_eew = SEW8;
      WIDTH16: ls_eew = SEW16;
      WIDTH32: ls_eew = SEW32;
      default: ls_legal = 1'b0;
    endcase
    if (mop != 2'b00 || nf != 3'b000) begin
      ls_legal = 1'b0;
    end
    // narrower memory element than sew shrinks the count
    if (cfg.sew == SEW32 && ls_eew == SEW8) begin
      ls_shift = 2'd2;
    end else if ((cfg.sew == SEW32 && ls_eew == SEW16) ||
                 (cfg.sew == SEW16 && ls_eew == SEW8)) begin
      ls_shift = 2'd1;
    end else begin
      ls_shift = 2'd0;
    end
  end

  always_comb begin
    ctrl          = '0;
    ctrl.vs1      = instr[19:15];
    ctrl.vs2      = instr[24:20];
    ctrl.vd       = instr[11:7];
    ctrl.vm       = instr[25];
    ctrl.imm      = {{(`VDEC_XLEN-5){instr[19]}}, instr[19:15]};
    ctrl.op       = VOP_ILLEGAL;
    ctrl.opnd_src = OPND_VS1;
    ctrl.vs2_src  = VS2_SRC_NORMAL;
    ctrl.eew      = cfg.sew;
    ctrl.elem_vl  = cfg.vl;

    case (opcode)
      OPC_OPV: begin
        case (funct6)
          F6_VADD: begin
            if (funct3 == F3_IVV) begin
              ctrl.op = VOP_ADD;
            end else if (funct3 == F3_IVX) begin
              ctrl.op       = VOP_ADD;
              ctrl.opnd_src = OPND_XS1;
            end else if (funct3 == F3_IVI) begin
              ctrl.op       = VOP_ADD;
              ctrl.opnd_src = OPND_IMM;
            end
          end
          F6_VRGATHER: begin
            if (funct3 == F3_IVV) begin
              ctrl.op      = VOP_RGATHER;
              ctrl.vs2_src = VS2_SRC_VS1;
            end
          end
          F6_VSLIDE1UP: begin
            // same funct6 under OPIVX is vslideup, not supported
            if (funct3 == F3_MVX) begin
              ctrl.op       = VOP_SLIDE1UP;
              ctrl.opnd_src = OPND_XS1;
              ctrl.vs2_src  = VS2_SRC_IDX_MINUS_1;
            end
          end
          F6_VSLIDE1DN: begin
            if (funct3 == F3_MVX) begin
              ctrl.op       = VOP_SLIDE1DOWN;
              ctrl.opnd_src = OPND_XS1;
              ctrl.vs2_src  = VS2_SRC_IDX_PLUS_1;
            end
          end
          default: ctrl.op = VOP_ILLEGAL;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        if (ls_legal) begin
          ctrl.op       = (opcode == OPC_LOAD) ? VOP_LOAD : VOP_STORE;
          ctrl.is_load  = (opcode == OPC_LOAD);
          ctrl.is_store = (opcode == OPC_STORE);
          ctrl.eew      = ls_eew;
          ctrl.elem_vl  = cfg.vl >> ls_shift;
        end
      end
      default: ctrl.op = VOP_ILLEGAL;
    endcase

    // nothing to walk for an unknown instruction
    if (ctrl.op == VOP_ILLEGAL) begin
      ctrl.elem_vl = '0;
    end
  end

endmodule

//--- verilog/vde_register.sv
// decode/execute register of the vector pipe
// stall holds the whole bundle, flush clears valid, wen and decode_done
// a flush in the same cycle as a stall still clears the control bits
`timescale 1ns/1ns
`include "vdec_defines.svh"

module vde_register (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   stall,
  input  logic                   flush,
  input  logic                   active,
  input  logic                   done,
  input  vdec_pkg::vctrl_t       ctrl,
  input  logic [`VDEC_XLEN-1:0]  xs1,
  input  vdec_pkg::rf_rsp_t      rf_rsp,
  input  logic [`VDEC_OFF_W-1:0] vs2_off0,
  input  logic [`VDEC_OFF_W-1:0] vs2_off1,
  input  logic [`VDEC_OFF_W-1:0] woffset0,
  input  logic [`VDEC_OFF_W-1:0] woffset1,
  input  logic [1:0]             wen,
  output vdec_pkg::de_bundle_t   de_out
);
  import vdec_pkg::*;

  logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0] vs2_off;
  logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  opnd_d;
  logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  vs2_d;

  // control part
  logic                   valid_q;
  logic [`VDEC_LANES-1:0] wen_q;
  logic                   done_q;

  // payload part
  vop_t                                    op_q;
  logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  opnd_q;
  logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  vs2_q;
  logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  sdata_q;
  logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0] woff_q;
  logic [`VDEC_REG_W-1:0]                  vd_q;
  sew_t                                    sew_q;
  logic [`VDEC_OFF_W-1:0]                  elem_vl_q;

  assign vs2_off[0] = vs2_off0;
  assign vs2_off[1] = vs2_off1;

  always_comb begin
    for (int i = 0; i < `VDEC_LANES; i++) begin
      case (ctrl.opnd_src)
        OPND_XS1: opnd_d[i] = xs1;
        OPND_IMM: opnd_d[i] = ctrl.imm;
        default:  opnd_d[i] = rf_rsp.vs1_data[i];
      endcase

      // scalar fills the element vacated by the slide
      if (ctrl.vs2_src == VS2_SRC_IDX_MINUS_1 && vs2_off[i] == '1) begin
        vs2_d[i] = xs1;
      end else if (ctrl.vs2_src == VS2_SRC_IDX_PLUS_1 && vs2_off[i] == ctrl.elem_vl) begin
        vs2_d[i] = xs1;
      end else begin
        vs2_d[i] = rf_rsp.vs2_data[i];
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
      wen_q   <= '0;
      done_q  <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
      wen_q   <= '0;
      done_q  <= 1'b0;
    end else if (!stall) begin
      valid_q <= active;
      wen_q   <= active ? wen : '0;
      done_q  <= done;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      op_q       <= ctrl.op;
      opnd_q     <= opnd_d;
      vs2_q      <= vs2_d;
      sdata_q    <= rf_rsp.vs3_data;
      woff_q[0]  <= woffset0;
      woff_q[1]  <= woffset1;
      vd_q       <= ctrl.vd;
      sew_q      <= ctrl.eew;
      elem_vl_q  <= ctrl.elem_vl;
    end
  end

  always_comb begin
    de_out.valid       = valid_q;
    de_out.op          = op_q;
    de_out.opnd        = opnd_q;
    de_out.vs2         = vs2_q;
    de_out.store_data  = sdata_q;
    de_out.woffset     = woff_q;
    de_out.vd          = vd_q;
    de_out.wen         = wen_q;
    de_out.sew         = sew_q;
    de_out.elem_vl     = elem_vl_q;
    de_out.decode_done = done_q;
  end

endmodule

//--- verilog/vdec_defines.svh
// sizing of the two-lane vector decode stage
// lane count is fixed at two by the port lists of the RTL
// offsets and element counts share one width
`ifndef VDEC_DEFINES_SVH
`define VDEC_DEFINES_SVH

// vector register length in bits and bytes
`define VDEC_VLEN 128
`define VDEC_VLENB (`VDEC_VLEN / 8)

// elements handled per step
`define VDEC_LANES 2

// scalar operand width
`define VDEC_XLEN 32

// element offset width, also used for vl
`define VDEC_OFF_W 32

// register number width
`define VDEC_REG_W 5

`endif

//--- verilog/vdec_pkg.sv
// types shared by the vector decode stage and its testbench
// width_t values follow the width field of the load/store encoding
// lane arrays are indexed by lane number, lane 0 is the lower element
`include "vdec_defines.svh"

package vdec_pkg;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  typedef enum logic [2:0] {
    VOP_ADD,
    VOP_SLIDE1UP,
    VOP_SLIDE1DOWN,
    VOP_RGATHER,
    VOP_LOAD,
    VOP_STORE,
    VOP_ILLEGAL
  } vop_t;

  // first operand of the execute stage
  typedef enum logic [1:0] {
    OPND_VS1,
    OPND_XS1,
    OPND_IMM
  } opnd_src_t;

  // how vs2 read offsets relate to the element offset
  typedef enum logic [1:0] {
    VS2_SRC_NORMAL,
    VS2_SRC_IDX_PLUS_1,
    VS2_SRC_IDX_MINUS_1,
    VS2_SRC_VS1
  } vs2_src_t;

  typedef struct packed {
    sew_t                   sew;
    logic [`VDEC_OFF_W-1:0] vl;
    logic [2:0]             lmul;
  } vcfg_t;

  typedef struct packed {
    vop_t                   op;
    opnd_src_t              opnd_src;
    vs2_src_t               vs2_src;
    logic [`VDEC_REG_W-1:0] vs1;
    logic [`VDEC_REG_W-1:0] vs2;
    logic [`VDEC_REG_W-1:0] vd;
    logic                   vm;
    logic [`VDEC_XLEN-1:0]  imm;
    logic                   is_load;
    logic                   is_store;
    sew_t                   eew;
    logic [`VDEC_OFF_W-1:0] elem_vl;
  } vctrl_t;

  typedef struct packed {
    logic [`VDEC_REG_W-1:0]                   vs1;
    logic [`VDEC_REG_W-1:0]                   vs2;
    logic [`VDEC_REG_W-1:0]                   vs3;
    logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0]  vs1_off;
    logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0]  vs2_off;
    logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0]  vs3_off;
    sew_t                                     sew;
  } rf_req_t;

  typedef struct packed {
    logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0] vs1_data;
    logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0] vs2_data;
    logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0] vs3_data;
    // v0 mask bits of the two elements
    logic [`VDEC_LANES-1:0]                 mask;
  } rf_rsp_t;

  typedef struct packed {
    logic                                    valid;
    vop_t                                    op;
    logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  opnd;
    logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  vs2;
    logic [`VDEC_LANES-1:0][`VDEC_XLEN-1:0]  store_data;
    logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0] woffset;
    logic [`VDEC_REG_W-1:0]                  vd;
    logic [`VDEC_LANES-1:0]                  wen;
    sew_t                                    sew;
    logic [`VDEC_OFF_W-1:0]                  elem_vl;
    logic                                    decode_done;
  } de_bundle_t;

endpackage

//--- verilog/vdecode_stage.sv
// decode stage of the two-lane vector unit
// instr, cfg, xs1 and xs2 must be held for the whole instruction
// next v_start only after v_busy has fallen
`timescale 1ns/1ns
`include "vdec_defines.svh"

module vdecode_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  v_start,
  input  logic [31:0]           instr,
  input  vdec_pkg::vcfg_t       cfg,
  input  logic [`VDEC_XLEN-1:0] xs1,
  input  logic [`VDEC_XLEN-1:0] xs2,
  input  logic                  stall,
  input  logic                  flush,
  input  vdec_pkg::rf_rsp_t     rf_rsp,
  output vdec_pkg::rf_req_t     rf_req,
  output vdec_pkg::de_bundle_t  de_out,
  output logic                  v_busy
);
  import vdec_pkg::*;

  vctrl_t                 ctrl;
  logic [`VDEC_OFF_W-1:0] offset;
  logic                   active;
  logic                   done;
  logic [`VDEC_OFF_W-1:0] woffset0;
  logic [`VDEC_OFF_W-1:0] woffset1;
  logic [1:0]             wen;

  vctrl_decode u_decode (
    .instr (instr),
    .cfg   (cfg),
    .ctrl  (ctrl)
  );

  velem_counter u_counter (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (v_start),
    .stall   (stall),
    .flush   (flush),
    .elem_vl (ctrl.elem_vl),
    .offset  (offset),
    .active  (active),
    .done    (done),
    .busy    (v_busy)
  );

  voffset_gen u_offset (
    .ctrl     (ctrl),
    .offset   (offset),
    .xs1      (xs1),
    .rf_rsp   (rf_rsp),
    .rf_req   (rf_req),
    .woffset0 (woffset0),
    .woffset1 (woffset1),
    .wen      (wen)
  );

  // xs2 carries no stride for unit-stride accesses
  vde_register u_de_reg (
    .CLK      (CLK),
    .nRST     (nRST),
    .stall    (stall),
    .flush    (flush),
    .active   (active),
    .done     (done),
    .ctrl     (ctrl),
    .xs1      (xs1),
    .rf_rsp   (rf_rsp),
    .vs2_off0 (rf_req.vs2_off[0]),
    .vs2_off1 (rf_req.vs2_off[1]),
    .woffset0 (woffset0),
    .woffset1 (woffset1),
    .wen      (wen),
    .de_out   (de_out)
  );

endmodule

//--- verilog/velem_counter.sv
// element pair counter, starts on a one-cycle start strobe
// offset 0 is loaded on the start edge, active follows from the next cycle
// busy drops two cycles after the last pair leaves an unstalled cycle
`timescale 1ns/1ns
`include "vdec_defines.svh"

module velem_counter (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   start,
  input  logic                   stall,
  input  logic                   flush,
  input  logic [`VDEC_OFF_W-1:0] elem_vl,
  output logic [`VDEC_OFF_W-1:0] offset,
  output logic                   active,
  output logic                   done,
  output logic                   busy
);
  logic running;
  logic last_pair;
  logic done_seen;
  logic busy_q;

  // also true for elem_vl of zero, so that case ends at once
  assign last_pair = (offset + `VDEC_OFF_W'(`VDEC_LANES)) >= elem_vl;
  assign active    = running;
  assign done      = running & last_pair;
  assign busy      = busy_q | start;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset  <= '0;
      running <= 1'b0;
    end else if (flush) begin
      running <= 1'b0;
    end else if (start) begin
      offset  <= '0;
      running <= 1'b1;
    end else if (running && !stall) begin
      if (last_pair) begin
        running <= 1'b0;
      end else begin
        offset <= offset + `VDEC_OFF_W'(`VDEC_LANES);
      end
    end
  end

  // last pair accepted by the output register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done_seen <= 1'b0;
    end else if (flush) begin
      done_seen <= 1'b0;
    end else begin
      done_seen <= done & ~stall;
    end
  end

  // busy latch toward the hazard unit
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy_q <= 1'b0;
    end else if (flush) begin
      busy_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (done_seen) begin
      busy_q <= 1'b0;
    end
  end

endmodule

//--- verilog/voffset_gen.sv
// read and write offsets of the current element pair
// register file answers rf_req in the same cycle
// vrgather uses the vs1 words of this cycle as vs2 read offsets
`timescale 1ns/1ns
`include "vdec_defines.svh"

module voffset_gen (
  input  vdec_pkg::vctrl_t       ctrl,
  input  logic [`VDEC_OFF_W-1:0] offset,
  input  logic [`VDEC_XLEN-1:0]  xs1,
  input  vdec_pkg::rf_rsp_t      rf_rsp,
  output vdec_pkg::rf_req_t      rf_req,
  output logic [`VDEC_OFF_W-1:0] woffset0,
  output logic [`VDEC_OFF_W-1:0] woffset1,
  output logic [1:0]             wen
);
  import vdec_pkg::*;

  logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0] lane_idx;
  logic [`VDEC_LANES-1:0][`VDEC_OFF_W-1:0] vs2_off;
  logic [`VDEC_LANES-1:0]                  lane_wen;

  always_comb begin
    for (int i = 0; i < `VDEC_LANES; i++) begin
      lane_idx[i] = offset + `VDEC_OFF_W'(i);
    end
  end

  always_comb begin
    for (int i = 0; i < `VDEC_LANES; i++) begin
      case (ctrl.vs2_src)
        VS2_SRC_IDX_PLUS_1:  vs2_off[i] = lane_idx[i] + `VDEC_OFF_W'(1);
        // lane 0 of the first pair reads offset -1, replaced later by xs1
        VS2_SRC_IDX_MINUS_1: vs2_off[i] = lane_idx[i] - `VDEC_OFF_W'(1);
        VS2_SRC_VS1:         vs2_off[i] = rf_rsp.vs1_data[i];
        default:             vs2_off[i] = lane_idx[i];
      endcase
    end
  end

  // store data comes from vd as vs3, so no write for stores
  always_comb begin
    for (int i = 0; i < `VDEC_LANES; i++) begin
      if (ctrl.is_store || lane_idx[i] >= ctrl.elem_vl) begin
        lane_wen[i] = 1'b0;
      end else if (!ctrl.vm) begin
        lane_wen[i] = rf_rsp.mask[i];
      end else begin
        lane_wen[i] = 1'b1;
      end
    end
  end

  always_comb begin
    rf_req         = '0;
    rf_req.vs1     = ctrl.vs1;
    rf_req.vs2     = ctrl.vs2;
    rf_req.vs3     = ctrl.vd;
    rf_req.vs1_off = lane_idx;
    rf_req.vs2_off = vs2_off;
    rf_req.vs3_off = lane_idx;
    rf_req.sew     = ctrl.eew;
  end

  assign woffset0 = lane_idx[0];
  assign woffset1 = lane_idx[1];
  assign wen      = lane_wen;

endmodule
